// File: logic/alu_station.sv
// ALU reservation station
`timescale 1ns/1ps
`default_nettype none

module alu_station #(
    parameter int DEPTH = 2
) (
    input  logic               clk_in,
    input  logic               rst_n,
    input  logic               rdy_in,
    input  logic               dispatch,
    input  ooo_pkg::rs_entry_t dispatch_entry,
    output logic               full,
    input  ooo_pkg::cdb_t      cdb,
    output logic               request,
    input  logic               grant,
    output ooo_pkg::cdb_t      result
);
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rs_entry_t        slot [DEPTH];
    logic [DEPTH-1:0] used;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] ready_idx;
    logic             have_ready;

    function automatic word_t alu(input rs_entry_t e);
        word_t a;
        word_t b;
        a = e.src1.value;
        b = e.use_imm ? e.imm : e.src2.value;
        case (e.op)
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_LUI:  return b;
            default:  return a + b;
        endcase
    endfunction

    // Lowest free slot and lowest slot with both operands in hand
    always_comb begin
        free_idx   = '0;
        ready_idx  = '0;
        have_ready = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!used[i]) begin
                free_idx = IDX_W'(i);
            end
            if (used[i] && !slot[i].src1.busy && !slot[i].src2.busy) begin
                ready_idx  = IDX_W'(i);
                have_ready = 1'b1;
            end
        end
    end

    assign full    = &used;
    assign request = result.valid;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            used         <= '0;
            result.valid <= 1'b0;
        end else if (rdy_in) begin
            // Wake-up of operands waiting on the bus tag
            for (int i = 0; i < DEPTH; i++) begin
                if (cdb.valid && slot[i].src1.busy && slot[i].src1.tag == cdb.tag) begin
                    slot[i].src1.busy  <= 1'b0;
                    slot[i].src1.value <= cdb.value;
                end
                if (cdb.valid && slot[i].src2.busy && slot[i].src2.tag == cdb.tag) begin
                    slot[i].src2.busy  <= 1'b0;
                    slot[i].src2.value <= cdb.value;
                end
            end
            if (dispatch && !full) begin
                slot[free_idx] <= dispatch_entry;
                used[free_idx] <= 1'b1;
            end
            if (grant) begin
                result.valid <= 1'b0;
            end else if (!result.valid && have_ready) begin
                result          <= '{valid: 1'b1, tag: slot[ready_idx].dest,
                                     value: alu(slot[ready_idx])};
                used[ready_idx] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/cdb_arbiter.sv
// Common data bus arbiter
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic          clk_in,
    input  logic          rst_n,
    input  logic          rdy_in,
    input  logic [1:0]    request,
    input  ooo_pkg::cdb_t result0,
    input  ooo_pkg::cdb_t result1,
    output logic [1:0]    grant,
    output ooo_pkg::cdb_t cdb
);
    // Set when station 1 held the bus last
    logic last_one;

    always_comb begin
        if (&request) begin
            grant = last_one ? 2'b01 : 2'b10;
        end else begin
            grant = request;
        end
    end

    assign cdb = grant[1] ? result1 : (grant[0] ? result0 : '0);

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            last_one <= 1'b1;
        end else if (rdy_in && |grant) begin
            last_one <= grant[1];
        end
    end

endmodule

`default_nettype wire

// File: logic/core_settings.svh
// Core sizing
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Fetched instructions waiting for issue
`define INST_QUEUE_DEPTH 8

// In-flight instructions
// Must be a power of two
`define ROB_DEPTH 8

// Entries per ALU reservation station
`define RS_DEPTH 2

`endif

// File: logic/inst_queue.sv
// Instruction queue
`timescale 1ns/1ps
`default_nettype none

module inst_queue #(
    parameter int DEPTH = 8
) (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  logic                 rdy_in,
    input  logic                 wr_en,
    input  ooo_pkg::inst_entry_t wr_data,
    input  logic                 pop,
    output ooo_pkg::inst_entry_t head,
    output logic                 empty,
    output logic                 full
);
    import ooo_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    inst_entry_t      mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             take;

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));
    assign head  = mem[rd_ptr];

    // Strobes into a full queue are dropped
    assign push = rdy_in && wr_en && !full;
    assign take = rdy_in && pop && !empty;

    always_ff @(posedge clk_in) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(take);
        end
    end

endmodule

`default_nettype wire

// File: logic/isa_pkg.sv
// RV32I instruction set types
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_id_t;

    // Major opcodes handled by the core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

endpackage

`default_nettype wire

// File: logic/issue.sv
// Decode and dispatch
`timescale 1ns/1ps
`default_nettype none

module issue (
    input  logic                 rdy_in,
    input  ooo_pkg::inst_entry_t head,
    input  logic                 empty,
    output logic                 pop,
    output isa_pkg::reg_id_t     rs1_id,
    output isa_pkg::reg_id_t     rs2_id,
    input  ooo_pkg::operand_t    reg_read1,
    input  ooo_pkg::operand_t    reg_read2,
    input  ooo_pkg::operand_t    rob_read1,
    input  ooo_pkg::operand_t    rob_read2,
    input  logic                 rob_full,
    input  ooo_pkg::rob_id_t     rob_tail,
    output ooo_pkg::rob_alloc_t  rob_alloc,
    input  logic [1:0]           station_full,
    output logic [1:0]           dispatch,
    output ooo_pkg::rs_entry_t   dispatch_entry
);
    import isa_pkg::*;
    import ooo_pkg::*;

    word_t    inst;
    alu_op_e  op;
    logic     use_imm;
    word_t    imm;
    operand_t src1;
    operand_t src2;
    logic     go;

    // Register value unless its producer is still pending
    function automatic operand_t merge(input operand_t reg_side, input operand_t rob_side);
        operand_t opd;
        opd = reg_side;
        if (reg_side.busy && !rob_side.busy) begin
            opd.busy  = 1'b0;
            opd.value = rob_side.value;
        end
        return opd;
    endfunction

    assign inst   = head.inst;
    assign rs1_id = inst[19:15];
    assign rs2_id = inst[24:20];

    always_comb begin
        op      = ALU_ADD;
        use_imm = 1'b0;
        imm     = '0;
        case (inst[6:0])
            OPC_LUI: begin
                op      = ALU_LUI;
                use_imm = 1'b1;
                imm     = {inst[31:12], 12'b0};
            end
            OPC_OP, OPC_OP_IMM: begin
                use_imm = (inst[6:0] == OPC_OP_IMM);
                imm     = {{20{inst[31]}}, inst[31:20]};
                case (inst[14:12])
                    3'b000:  op = (!use_imm && inst[30]) ? ALU_SUB : ALU_ADD;
                    3'b001:  op = ALU_SLL;
                    3'b010:  op = ALU_SLT;
                    3'b011:  op = ALU_SLTU;
                    3'b100:  op = ALU_XOR;
                    3'b101:  op = inst[30] ? ALU_SRA : ALU_SRL;
                    3'b110:  op = ALU_OR;
                    default: op = ALU_AND;
                endcase
            end
            default: ;
        endcase
    end

    // Fields reused as immediate bits never wait on a producer
    always_comb begin
        src1 = merge(reg_read1, rob_read1);
        src2 = merge(reg_read2, rob_read2);
        if (op == ALU_LUI) begin
            src1.busy = 1'b0;
        end
        if (use_imm) begin
            src2.busy = 1'b0;
        end
    end

    assign go  = rdy_in && !empty && !rob_full && !(&station_full);
    assign pop = go;

    // Station 0 first, station 1 when 0 is full
    assign dispatch = !go ? 2'b00 : (station_full[0] ? 2'b10 : 2'b01);

    assign rob_alloc = '{valid: go, rd: inst[11:7], addr: head.addr, tag: rob_tail};

    assign dispatch_entry = '{op: op, dest: rob_tail, src1: src1, src2: src2,
                              use_imm: use_imm, imm: imm};

endmodule

`default_nettype wire

// File: logic/ooo_core.sv
// Out-of-order core top
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module ooo_core (
    input  logic             clk_in,
    input  logic             rst_n,
    input  logic             rdy_in,
    input  isa_pkg::word_t   inst_in,
    input  isa_pkg::addr_t   inst_addr,
    input  logic             inst_ready_in,
    output logic             inst_queue_full,
    output ooo_pkg::commit_t commit
);
    import isa_pkg::*;
    import ooo_pkg::*;

    inst_entry_t head;
    logic        empty;
    logic        pop;
    reg_id_t     rs1_id;
    reg_id_t     rs2_id;
    operand_t    reg_read1;
    operand_t    reg_read2;
    operand_t    rob_read1;
    operand_t    rob_read2;
    logic        rob_full;
    rob_id_t     rob_tail;
    rob_alloc_t  rob_alloc;
    logic [1:0]  station_full;
    logic [1:0]  dispatch;
    rs_entry_t   dispatch_entry;
    logic [1:0]  request;
    logic [1:0]  grant;
    cdb_t        result0;
    cdb_t        result1;
    cdb_t        cdb;
    commit_t     retire;
    rob_id_t     retire_tag;

    inst_queue #(.DEPTH(`INST_QUEUE_DEPTH)) i_inst_queue (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rdy_in  (rdy_in),
        .wr_en   (inst_ready_in),
        .wr_data ({inst_in, inst_addr}),
        .pop     (pop),
        .head    (head),
        .empty   (empty),
        .full    (inst_queue_full)
    );

    issue i_issue (
        .rdy_in         (rdy_in),
        .head           (head),
        .empty          (empty),
        .pop            (pop),
        .rs1_id         (rs1_id),
        .rs2_id         (rs2_id),
        .reg_read1      (reg_read1),
        .reg_read2      (reg_read2),
        .rob_read1      (rob_read1),
        .rob_read2      (rob_read2),
        .rob_full       (rob_full),
        .rob_tail       (rob_tail),
        .rob_alloc      (rob_alloc),
        .station_full   (station_full),
        .dispatch       (dispatch),
        .dispatch_entry (dispatch_entry)
    );

    reg_status i_reg_status (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .rs1_id     (rs1_id),
        .rs2_id     (rs2_id),
        .reg_read1  (reg_read1),
        .reg_read2  (reg_read2),
        .rob_alloc  (rob_alloc),
        .retire     (retire),
        .retire_tag (retire_tag)
    );

    // Producer tags from the register file go straight to the ROB
    reorder_buffer i_reorder_buffer (
        .clk_in     (clk_in),
        .rst_n      (rst_n),
        .rdy_in     (rdy_in),
        .rob_alloc  (rob_alloc),
        .full       (rob_full),
        .tail       (rob_tail),
        .cdb        (cdb),
        .query1     (reg_read1.tag),
        .query2     (reg_read2.tag),
        .answer1    (rob_read1),
        .answer2    (rob_read2),
        .commit     (commit),
        .retire     (retire),
        .retire_tag (retire_tag)
    );

    alu_station #(.DEPTH(`RS_DEPTH)) i_station0 (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .dispatch       (dispatch[0]),
        .dispatch_entry (dispatch_entry),
        .full           (station_full[0]),
        .cdb            (cdb),
        .request        (request[0]),
        .grant          (grant[0]),
        .result         (result0)
    );

    alu_station #(.DEPTH(`RS_DEPTH)) i_station1 (
        .clk_in         (clk_in),
        .rst_n          (rst_n),
        .rdy_in         (rdy_in),
        .dispatch       (dispatch[1]),
        .dispatch_entry (dispatch_entry),
        .full           (station_full[1]),
        .cdb            (cdb),
        .request        (request[1]),
        .grant          (grant[1]),
        .result         (result1)
    );

    cdb_arbiter i_cdb_arbiter (
        .clk_in  (clk_in),
        .rst_n   (rst_n),
        .rdy_in  (rdy_in),
        .request (request),
        .result0 (result0),
        .result1 (result1),
        .grant   (grant),
        .cdb     (cdb)
    );

endmodule

`default_nettype wire

// File: logic/ooo_pkg.sv
// Out-of-order machinery types
`default_nettype none

`include "core_settings.svh"

package ooo_pkg;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_id_t;

    typedef struct packed {
        isa_pkg::word_t inst;
        isa_pkg::addr_t addr;
    } inst_entry_t;

    // Tag is only meaningful while busy
    typedef struct packed {
        logic           busy;
        rob_id_t        tag;
        isa_pkg::word_t value;
    } operand_t;

    typedef struct packed {
        isa_pkg::alu_op_e op;
        rob_id_t          dest;
        operand_t         src1;
        operand_t         src2;
        logic             use_imm;
        isa_pkg::word_t   imm;
    } rs_entry_t;

    typedef struct packed {
        logic             valid;
        isa_pkg::reg_id_t rd;
        isa_pkg::addr_t   addr;
        rob_id_t          tag;
    } rob_alloc_t;

    typedef struct packed {
        logic           valid;
        rob_id_t        tag;
        isa_pkg::word_t value;
    } cdb_t;

    typedef struct packed {
        logic             valid;
        isa_pkg::reg_id_t rd;
        isa_pkg::word_t   value;
        isa_pkg::addr_t   addr;
    } commit_t;

    typedef enum logic [1:0] {
        ROB_FREE,
        ROB_WAITING,
        ROB_DONE
    } rob_state_e;

endpackage

`default_nettype wire

// File: logic/reg_status.sv
// Renaming register file
`timescale 1ns/1ps
`default_nettype none

module reg_status (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy_in,
    input  isa_pkg::reg_id_t    rs1_id,
    input  isa_pkg::reg_id_t    rs2_id,
    output ooo_pkg::operand_t   reg_read1,
    output ooo_pkg::operand_t   reg_read2,
    input  ooo_pkg::rob_alloc_t rob_alloc,
    input  ooo_pkg::commit_t    retire,
    input  ooo_pkg::rob_id_t    retire_tag
);
    import isa_pkg::*;
    import ooo_pkg::*;

    word_t   values [32];
    logic    busy   [32];
    rob_id_t tags   [32];

    // x0 reads as a ready zero
    assign reg_read1 = (rs1_id == '0) ? '0 : '{busy: busy[rs1_id], tag: tags[rs1_id],
                                               value: values[rs1_id]};
    assign reg_read2 = (rs2_id == '0) ? '0 : '{busy: busy[rs2_id], tag: tags[rs2_id],
                                               value: values[rs2_id]};

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                values[i] <= '0;
                busy[i]   <= 1'b0;
            end
        end else if (rdy_in) begin
            if (retire.valid && retire.rd != '0) begin
                values[retire.rd] <= retire.value;
                // Stale tag leaves a newer rename alone
                if (tags[retire.rd] == retire_tag) begin
                    busy[retire.rd] <= 1'b0;
                end
            end
            // Allocation comes last so it wins for the same register
            if (rob_alloc.valid && rob_alloc.rd != '0) begin
                busy[rob_alloc.rd] <= 1'b1;
                tags[rob_alloc.rd] <= rob_alloc.tag;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/reorder_buffer.sv
// Reorder buffer
`timescale 1ns/1ps
`default_nettype none

`include "core_settings.svh"

module reorder_buffer (
    input  logic                clk_in,
    input  logic                rst_n,
    input  logic                rdy_in,
    input  ooo_pkg::rob_alloc_t rob_alloc,
    output logic                full,
    output ooo_pkg::rob_id_t    tail,
    input  ooo_pkg::cdb_t       cdb,
    input  ooo_pkg::rob_id_t    query1,
    input  ooo_pkg::rob_id_t    query2,
    output ooo_pkg::operand_t   answer1,
    output ooo_pkg::operand_t   answer2,
    output ooo_pkg::commit_t    commit,
    output ooo_pkg::commit_t    retire,
    output ooo_pkg::rob_id_t    retire_tag
);
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int DEPTH = `ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    rob_state_e       state  [DEPTH];
    reg_id_t          rd     [DEPTH];
    addr_t            addr   [DEPTH];
    word_t            value  [DEPTH];
    rob_id_t          head;
    logic [CNT_W-1:0] count;
    logic             retire_go;
    logic             alloc_go;

    // Done entries answer directly, results on the bus are forwarded
    function automatic operand_t lookup(input rob_id_t q);
        operand_t ans;
        ans = '{busy: 1'b1, tag: q, value: value[q]};
        if (state[q] == ROB_DONE) begin
            ans.busy = 1'b0;
        end else if (cdb.valid && cdb.tag == q) begin
            ans.busy  = 1'b0;
            ans.value = cdb.value;
        end
        return ans;
    endfunction

    assign answer1 = lookup(query1);
    assign answer2 = lookup(query2);

    assign full      = (count == CNT_W'(DEPTH));
    assign alloc_go  = rdy_in && rob_alloc.valid && !full;
    assign retire_go = rdy_in && (state[head] == ROB_DONE);

    assign retire     = '{valid: retire_go, rd: rd[head], value: value[head], addr: addr[head]};
    assign retire_tag = head;

    always_ff @(posedge clk_in) begin
        if (alloc_go) begin
            rd[tail]   <= rob_alloc.rd;
            addr[tail] <= rob_alloc.addr;
        end
        if (rdy_in && cdb.valid) begin
            value[cdb.tag] <= cdb.value;
        end
        if (retire_go) begin
            commit <= retire;
        end
        if (!rst_n) begin
            commit.valid <= 1'b0;
        end else begin
            commit.valid <= retire_go;   // one cycle only, even across a pause
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                state[i] <= ROB_FREE;
            end
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (rdy_in) begin
            if (cdb.valid) begin
                state[cdb.tag] <= ROB_DONE;
            end
            if (alloc_go) begin
                state[tail] <= ROB_WAITING;
                tail        <= tail + 1'b1;
            end
            if (retire_go) begin
                state[head] <= ROB_FREE;
                head        <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_go) - CNT_W'(retire_go);
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_ooo_core -o tb_ooo_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_ooo_core
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit $status
fi
exit 0

// File: src.f
+incdir+logic
logic/isa_pkg.sv
logic/ooo_pkg.sv
logic/inst_queue.sv
logic/issue.sv
logic/reg_status.sv
logic/reorder_buffer.sv
logic/alu_station.sv
logic/cdb_arbiter.sv
logic/ooo_core.sv
testbench/tb_ooo_core.sv

// File: testbench/tb_ooo_core.sv
// Out-of-order core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core;
    import isa_pkg::*;
    import ooo_pkg::*;

    localparam int WAIT_LIMIT  = 300;
    localparam int BURST_LIMIT = 100;

    logic    clk_in;
    logic    rst_n;
    logic    rdy_in;
    word_t   inst_in;
    addr_t   inst_addr;
    logic    inst_ready_in;
    logic    inst_queue_full;
    commit_t commit;

    // Reference state updated in program order as instructions are written
    word_t       model_regs [32];
    commit_t     expected_q [$];
    commit_t     exp_commit;
    logic [31:0] lfsr;
    addr_t       pc;
    logic        rdy_at_edge;
    logic        full_seen;

    ooo_core i_dut (
        .clk_in          (clk_in),
        .rst_n           (rst_n),
        .rdy_in          (rdy_in),
        .inst_in         (inst_in),
        .inst_addr       (inst_addr),
        .inst_ready_in   (inst_ready_in),
        .inst_queue_full (inst_queue_full),
        .commit          (commit)
    );

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string name, input word_t got, input word_t want);
        $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, want);
        $display("Testbench failed");
        $fatal(1, "run stopped");
    endtask

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return r;
    endfunction

    function automatic word_t r_type(input logic [2:0] f3, input logic alt, input reg_id_t rd,
                                     input reg_id_t rs1, input reg_id_t rs2);
        logic [6:0] funct7;
        funct7 = (alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        return {funct7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(input logic [2:0] f3, input reg_id_t rd,
                                     input reg_id_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t u_type(input reg_id_t rd, input logic [19:0] upper);
        return {upper, rd, 7'b0110111};
    endfunction

    // Legal ALU, immediate or LUI encoding over x0 to x7
    function automatic word_t random_inst();
        logic [1:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        reg_id_t     rd;
        reg_id_t     rs1;
        reg_id_t     rs2;
        logic [11:0] imm;
        kind = 2'(rand_bits(2));
        f3   = 3'(rand_bits(3));
        alt  = 1'(rand_bits(1));
        rd   = 5'(rand_bits(3));
        rs1  = 5'(rand_bits(3));
        rs2  = 5'(rand_bits(3));
        imm  = 12'(rand_bits(12));
        case (kind)
            2'd0: return r_type(f3, alt, rd, rs1, rs2);
            2'd3: return u_type(rd, {imm, 8'(rand_bits(8))});
            default: begin
                // Shift immediates carry only a shamt and the arithmetic bit
                if (f3 == 3'b001) begin
                    imm = {7'b0000000, imm[4:0]};
                end
                if (f3 == 3'b101) begin
                    imm = {alt ? 7'b0100000 : 7'b0000000, imm[4:0]};
                end
                return i_type(f3, rd, rs1, imm);
            end
        endcase
    endfunction

    // Reads and writes the same register so each one waits on the last
    function automatic word_t chain_inst(input reg_id_t r);
        word_t inst;
        inst = random_inst();
        if (inst[6:0] == 7'b0110111) begin
            inst = i_type(3'b000, r, r, inst[31:20]);
        end
        inst[11:7]  = r;
        inst[19:15] = r;
        return inst;
    endfunction

    // Result under RV32I rules from the model registers
    function automatic word_t model_result(input word_t inst);
        word_t      a;
        word_t      b;
        logic [2:0] f3;
        logic       alt;
        f3  = inst[14:12];
        alt = inst[30];
        a   = model_regs[inst[19:15]];
        if (inst[6:0] == 7'b0110111) begin
            return {inst[31:12], 12'h000};
        end
        if (inst[6:0] == 7'b0010011) begin
            b   = {{20{inst[31]}}, inst[31:20]};
            alt = alt && (f3 == 3'b101);
        end else begin
            b = model_regs[inst[24:20]];
        end
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic send(input word_t inst);
        commit_t exp;
        int      waited;
        waited = 0;
        while (inst_queue_full) begin
            if (waited == WAIT_LIMIT) begin
                stop_with_failure("instruction queue stayed full too long");
            end
            waited++;
            @(posedge clk_in);
            #1;
        end
        exp.valid = 1'b1;
        exp.rd    = inst[11:7];
        exp.addr  = pc;
        exp.value = model_result(inst);
        if (inst[11:7] != 5'd0) begin
            model_regs[inst[11:7]] = exp.value;
        end
        expected_q.push_back(exp);
        inst_in       = inst;
        inst_addr     = pc;
        inst_ready_in = 1'b1;
        pc            = pc + 32'd4;
        @(posedge clk_in);
        #1;
        inst_ready_in = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_q.size() != 0) begin
            if (waited == WAIT_LIMIT) begin
                stop_with_failure("pending instructions never committed");
            end
            waited++;
            @(posedge clk_in);
            #1;
        end
    endtask

    always @(posedge clk_in) begin
        rdy_at_edge <= rdy_in;
    end

    // Commit outputs are registered, so the falling edge sees them settled
    always @(negedge clk_in) begin
        if (rst_n && commit.valid) begin
            assert (rdy_at_edge)
                else stop_with_failure("commit pulse while rdy_in was low");
            assert (expected_q.size() != 0)
                else stop_with_failure("commit pulse with no instruction pending");
            exp_commit = expected_q.pop_front();
            assert (commit.addr == exp_commit.addr)
                else value_error("commit.addr", commit.addr, exp_commit.addr);
            assert (commit.rd == exp_commit.rd)
                else value_error("commit.rd", 32'(commit.rd), 32'(exp_commit.rd));
            assert (commit.value == exp_commit.value)
                else value_error("commit.value", commit.value, exp_commit.value);
        end
    end

    initial begin
        rst_n         = 1'b0;
        rdy_in        = 1'b1;
        inst_in       = '0;
        inst_addr     = '0;
        inst_ready_in = 1'b0;
        lfsr          = 32'h124d;
        pc            = 32'h0000_1000;
        full_seen     = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (3) @(posedge clk_in);
        #1;
        rst_n = 1'b1;

        // Idle core after reset
        repeat (6) @(posedge clk_in);
        #1;
        assert (!inst_queue_full)
            else value_error("inst_queue_full", 32'(inst_queue_full), 32'd0);

        // Writes to x0 and reads of it
        send(i_type(3'b000, 5'd0, 5'd0, 12'd123));
        send(r_type(3'b000, 1'b0, 5'd5, 5'd0, 5'd0));
        send(i_type(3'b000, 5'd6, 5'd0, 12'd7));
        send(r_type(3'b000, 1'b1, 5'd7, 5'd6, 5'd0));
        send(r_type(3'b110, 1'b0, 5'd0, 5'd6, 5'd6));
        send(r_type(3'b000, 1'b0, 5'd4, 5'd0, 5'd6));
        wait_drained();

        // Mixed random program
        repeat (40) send(random_inst());
        wait_drained();

        // Back-to-back chain that renames x1 and x2 again and again
        send(i_type(3'b000, 5'd1, 5'd0, 12'd5));
        send(r_type(3'b000, 1'b0, 5'd1, 5'd1, 5'd1));
        send(i_type(3'b001, 5'd1, 5'd1, 12'd3));
        send(i_type(3'b000, 5'd2, 5'd1, 12'hfff));
        send(r_type(3'b000, 1'b1, 5'd1, 5'd2, 5'd1));
        send(r_type(3'b101, 1'b1, 5'd2, 5'd1, 5'd2));
        send(r_type(3'b011, 1'b0, 5'd3, 5'd1, 5'd2));
        wait_drained();

        // Dependent burst until the queue backs up
        for (int n = 0; n < BURST_LIMIT && !full_seen; n++) begin
            if (inst_queue_full) begin
                full_seen = 1'b1;
            end else begin
                send(chain_inst(5'd3));
            end
        end
        assert (full_seen)
            else stop_with_failure("instruction queue never filled during the burst");
        wait_drained();

        // Pause with work in flight
        repeat (6) send(chain_inst(5'd4));
        rdy_in = 1'b0;
        repeat (12) @(posedge clk_in);
        #1;
        rdy_in = 1'b1;
        wait_drained();

        // Quiet tail so a late extra commit still meets the checker
        repeat (4) @(posedge clk_in);
        #1;
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire
